/* rtl/alu.sv */
`timescale 1ns/1ps

module alu (
	input  rv_core_pkg::alu_op_t ex_op,
	input  rv_core_pkg::word_t   ex_pc,
	input  rv_core_pkg::word_t   ex_rs1,
	input  rv_core_pkg::word_t   ex_rs2,
	input  rv_core_pkg::word_t   ex_imm,
	input  logic                 ex_src_a_pc,
	input  rv_core_pkg::src_b_t  ex_src_b,
	output rv_core_pkg::word_t   result
);

	rv_core_pkg::word_t op_a;
	rv_core_pkg::word_t op_b;

	assign op_a = ex_src_a_pc ? ex_pc : ex_rs1;

	always_comb begin
		case (ex_src_b)
			rv_core_pkg::SRC_B_RS2:  op_b = ex_rs2;
			rv_core_pkg::SRC_B_FOUR: op_b = rv_core_pkg::INST_STEP; // Return address
			default:                 op_b = ex_imm;
		endcase
	end

	always_comb begin
		case (ex_op)
			rv_core_pkg::ALU_ADD:    result = op_a + op_b;
			rv_core_pkg::ALU_SUB:    result = op_a - op_b;
			rv_core_pkg::ALU_AND:    result = op_a & op_b;
			rv_core_pkg::ALU_OR:     result = op_a | op_b;
			rv_core_pkg::ALU_XOR:    result = op_a ^ op_b;
			rv_core_pkg::ALU_PASS_A: result = op_a;
			rv_core_pkg::ALU_LTU:    result = {31'd0, op_a < op_b};
			rv_core_pkg::ALU_LT:     result = {31'd0, $signed(op_a) < $signed(op_b)};
			rv_core_pkg::ALU_SLL:    result = op_a << op_b[4:0];
			rv_core_pkg::ALU_SRL:    result = op_a >> op_b[4:0];
			rv_core_pkg::ALU_SRA:    result = $signed(op_a) >>> op_b[4:0];
			rv_core_pkg::ALU_PASS_B: result = op_b; // LUI
			default:                 result = '0;
		endcase
	end

endmodule

/* rtl/id_ex_stage.sv */
`timescale 1ns/1ps

module id_ex_stage (
	input  logic                  clk,
	input  logic                  rst,
	input  rv_core_pkg::word_t    dec_pc,
	input  rv_core_pkg::word_t    imm,
	input  rv_isa_pkg::reg_addr_t rd_addr,
	input  rv_core_pkg::alu_op_t  alu_op,
	input  logic                  src_a_pc,
	input  rv_core_pkg::src_b_t   src_b,
	input  logic                  wr_en,
	input  logic                  jump_from_pc,
	input  rv_core_pkg::word_t    rs1_value,
	input  rv_core_pkg::word_t    rs2_value,
	input  logic                  redirect_req,
	input  logic                  boot_hold,
	output rv_core_pkg::word_t    ex_pc,
	output rv_core_pkg::word_t    ex_imm,
	output rv_core_pkg::word_t    ex_rs1,
	output rv_core_pkg::word_t    ex_rs2,
	output rv_core_pkg::alu_op_t  ex_op,
	output logic                  ex_src_a_pc,
	output rv_core_pkg::src_b_t   ex_src_b,
	output logic                  ex_wr_en,
	output rv_isa_pkg::reg_addr_t ex_rd,
	output logic                  redirect,
	output logic                  flush,
	output logic                  boot_hold_q,
	output rv_core_pkg::word_t    jump_target
);

	logic               ex_from_pc;
	rv_core_pkg::word_t target_base;
	rv_core_pkg::word_t target_sum;

	// ========================================================================
	// Control register, squashed the cycle after a redirect
	// ========================================================================
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ex_op       <= rv_core_pkg::ALU_ADD;
			ex_src_a_pc <= 1'b0;
			ex_src_b    <= rv_core_pkg::SRC_B_IMM;
			ex_wr_en    <= 1'b0;
			ex_rd       <= '0;
			ex_from_pc  <= 1'b0;
			redirect    <= 1'b0;
			boot_hold_q <= 1'b1; // PC stays at boot while leaving reset
		end else if (flush) begin
			ex_op       <= rv_core_pkg::ALU_ADD;
			ex_src_a_pc <= 1'b0;
			ex_src_b    <= rv_core_pkg::SRC_B_IMM;
			ex_wr_en    <= 1'b0;
			ex_rd       <= '0;
			ex_from_pc  <= 1'b0;
			redirect    <= 1'b0;
			boot_hold_q <= 1'b0;
		end else begin
			ex_op       <= alu_op;
			ex_src_a_pc <= src_a_pc;
			ex_src_b    <= src_b;
			ex_wr_en    <= wr_en & ~boot_hold; // No write-back during boot
			ex_rd       <= rd_addr;
			ex_from_pc  <= jump_from_pc;
			redirect    <= redirect_req;
			boot_hold_q <= boot_hold;
		end
	end

	always_ff @(posedge clk) begin
		ex_pc  <= dec_pc;
		ex_imm <= imm;
		ex_rs1 <= rs1_value;
		ex_rs2 <= rs2_value;
	end

	assign flush = redirect;

	assign target_base = ex_from_pc ? ex_pc : ex_rs1; // JALR uses rs1
	assign target_sum  = target_base + ex_imm;
	assign jump_target = {target_sum[31:1], 1'b0};

endmodule

/* rtl/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      flush,
	input  rv_isa_pkg::inst_t         inst,
	input  rv_core_pkg::word_t        pc,
	output rv_core_pkg::word_t        dec_pc,
	output rv_core_pkg::word_t        imm,
	output rv_isa_pkg::reg_addr_t     rs1_addr,
	output rv_isa_pkg::reg_addr_t     rs2_addr,
	output rv_isa_pkg::reg_addr_t     rd_addr,
	output rv_core_pkg::alu_op_t      alu_op,
	output logic                      src_a_pc,
	output rv_core_pkg::src_b_t       src_b,
	output logic                      wr_en,
	output logic                      is_branch,
	output logic                      is_jump,
	output logic                      jump_from_pc,
	output rv_core_pkg::branch_kind_t branch_kind
);

	rv_isa_pkg::inst_t    inst_q;
	rv_isa_pkg::opcode_t  opcode;
	rv_isa_pkg::funct3_t  funct3;
	rv_isa_pkg::funct7_t  funct7;
	rv_core_pkg::word_t   imm_i;
	rv_core_pkg::word_t   imm_b;
	rv_core_pkg::word_t   imm_j;
	rv_core_pkg::word_t   imm_u;

	// ========================================================================
	// Fetch/decode register
	// ========================================================================
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			inst_q <= rv_isa_pkg::NOP_INST;
		else if (flush)
			inst_q <= rv_isa_pkg::NOP_INST;
		else
			inst_q <= inst;
	end

	always_ff @(posedge clk) begin
		dec_pc <= pc;
	end

	assign opcode      = inst_q[6:0];
	assign rd_addr     = inst_q[11:7];
	assign funct3      = inst_q[14:12];
	assign rs1_addr    = inst_q[19:15];
	assign rs2_addr    = inst_q[24:20];
	assign funct7      = inst_q[31:25];
	assign branch_kind = funct3;

	assign imm_i = {{20{inst_q[31]}}, inst_q[31:20]};
	assign imm_b = {{20{inst_q[31]}}, inst_q[7], inst_q[30:25], inst_q[11:8], 1'b0};
	assign imm_j = {{12{inst_q[31]}}, inst_q[19:12], inst_q[20], inst_q[30:21], 1'b0};
	assign imm_u = {inst_q[31:12], 12'b0};

	always_comb begin
		case (opcode)
			rv_isa_pkg::OPC_BRANCH: imm = imm_b;
			rv_isa_pkg::OPC_JAL:    imm = imm_j;
			rv_isa_pkg::OPC_LUI,
			rv_isa_pkg::OPC_AUIPC:  imm = imm_u;
			default:                imm = imm_i; // OP-IMM, JALR
		endcase
	end

	// ========================================================================
	// Control decode
	// ========================================================================
	always_comb begin
		alu_op       = rv_core_pkg::ALU_ADD;
		src_a_pc     = 1'b0;
		src_b        = rv_core_pkg::SRC_B_IMM;
		wr_en        = 1'b0;
		is_branch    = 1'b0;
		is_jump      = 1'b0;
		jump_from_pc = 1'b1;
		case (opcode)
			rv_isa_pkg::OPC_OP_IMM: begin
				wr_en = 1'b1;
				case (funct3)
					rv_isa_pkg::F3_SLT:  alu_op = rv_core_pkg::ALU_LT;
					rv_isa_pkg::F3_SLTU: alu_op = rv_core_pkg::ALU_LTU;
					rv_isa_pkg::F3_XOR:  alu_op = rv_core_pkg::ALU_XOR;
					rv_isa_pkg::F3_OR:   alu_op = rv_core_pkg::ALU_OR;
					rv_isa_pkg::F3_AND:  alu_op = rv_core_pkg::ALU_AND;
					rv_isa_pkg::F3_SLL: begin
						alu_op = rv_core_pkg::ALU_SLL;
						wr_en  = (funct7 == rv_isa_pkg::F7_BASE);
					end
					rv_isa_pkg::F3_SR: begin
						alu_op = (funct7 == rv_isa_pkg::F7_ALT) ? rv_core_pkg::ALU_SRA
						                                         : rv_core_pkg::ALU_SRL;
						wr_en  = (funct7 == rv_isa_pkg::F7_BASE) || (funct7 == rv_isa_pkg::F7_ALT);
					end
					default:             alu_op = rv_core_pkg::ALU_ADD;
				endcase
			end
			rv_isa_pkg::OPC_OP: begin
				src_b = rv_core_pkg::SRC_B_RS2;
				if (funct7 == rv_isa_pkg::F7_BASE) begin
					wr_en = 1'b1;
					case (funct3)
						rv_isa_pkg::F3_SLL:  alu_op = rv_core_pkg::ALU_SLL;
						rv_isa_pkg::F3_SLT:  alu_op = rv_core_pkg::ALU_LT;
						rv_isa_pkg::F3_SLTU: alu_op = rv_core_pkg::ALU_LTU;
						rv_isa_pkg::F3_XOR:  alu_op = rv_core_pkg::ALU_XOR;
						rv_isa_pkg::F3_SR:   alu_op = rv_core_pkg::ALU_SRL;
						rv_isa_pkg::F3_OR:   alu_op = rv_core_pkg::ALU_OR;
						rv_isa_pkg::F3_AND:  alu_op = rv_core_pkg::ALU_AND;
						default:             alu_op = rv_core_pkg::ALU_ADD;
					endcase
				end else if (funct7 == rv_isa_pkg::F7_ALT) begin
					// Only SUB and SRA exist here
					wr_en  = (funct3 == rv_isa_pkg::F3_ADD) || (funct3 == rv_isa_pkg::F3_SR);
					alu_op = (funct3 == rv_isa_pkg::F3_SR) ? rv_core_pkg::ALU_SRA
					                                        : rv_core_pkg::ALU_SUB;
				end
			end
			rv_isa_pkg::OPC_BRANCH: is_branch = 1'b1;
			rv_isa_pkg::OPC_JAL,
			rv_isa_pkg::OPC_JALR: begin
				is_jump      = 1'b1;
				wr_en        = 1'b1;
				src_a_pc     = 1'b1;
				src_b        = rv_core_pkg::SRC_B_FOUR; // Link value pc+4
				jump_from_pc = (opcode == rv_isa_pkg::OPC_JAL);
			end
			rv_isa_pkg::OPC_LUI: begin
				wr_en  = 1'b1;
				alu_op = rv_core_pkg::ALU_PASS_B;
			end
			rv_isa_pkg::OPC_AUIPC: begin
				wr_en    = 1'b1;
				src_a_pc = 1'b1;
			end
			default: wr_en = 1'b0;
		endcase
	end

endmodule

/* rtl/pipeline_sequencer.sv */
`timescale 1ns/1ps

module pipeline_sequencer (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      is_branch,
	input  logic                      is_jump,
	input  rv_core_pkg::branch_kind_t branch_kind,
	input  rv_core_pkg::word_t        rs1_value,
	input  rv_core_pkg::word_t        rs2_value,
	output logic                      boot_hold,
	output logic                      redirect_req
);

	rv_core_pkg::seq_state_e state;
	rv_core_pkg::seq_state_e state_next;
	logic                    branch_taken;

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			state <= rv_core_pkg::SEQ_BOOT0;
		else
			state <= state_next;
	end

	always_comb begin
		unique case (state)
			rv_core_pkg::SEQ_BOOT0: state_next = rv_core_pkg::SEQ_BOOT1;
			rv_core_pkg::SEQ_BOOT1: state_next = rv_core_pkg::SEQ_RUN;
			default:                state_next = rv_core_pkg::SEQ_RUN;
		endcase
	end

	// ========================================================================
	// Branch resolution in decode
	// ========================================================================
	always_comb begin
		case (branch_kind)
			rv_isa_pkg::F3_BEQ:  branch_taken = (rs1_value == rs2_value);
			rv_isa_pkg::F3_BNE:  branch_taken = (rs1_value != rs2_value);
			rv_isa_pkg::F3_BLT:  branch_taken = ($signed(rs1_value) < $signed(rs2_value));
			rv_isa_pkg::F3_BGE:  branch_taken = ($signed(rs1_value) >= $signed(rs2_value));
			rv_isa_pkg::F3_BLTU: branch_taken = (rs1_value < rs2_value);
			rv_isa_pkg::F3_BGEU: branch_taken = (rs1_value >= rs2_value);
			default:             branch_taken = 1'b0; // 010/011 are not branches
		endcase
	end

	assign boot_hold    = (state != rv_core_pkg::SEQ_RUN);
	assign redirect_req = boot_hold | is_jump | (is_branch & branch_taken);

endmodule

/* rtl/program_counter.sv */
`timescale 1ns/1ps

module program_counter #(
	parameter rv_core_pkg::word_t boot_addr = 32'h0000_0000
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               boot_hold,
	input  logic               redirect,
	input  rv_core_pkg::word_t jump_target,
	output rv_core_pkg::word_t pc
);

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			pc <= boot_addr;
		else if (boot_hold) // Boot wins over any stale redirect
			pc <= boot_addr;
		else if (redirect)
			pc <= jump_target;
		else
			pc <= pc + rv_core_pkg::INST_STEP;
	end

endmodule

/* rtl/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
	input  logic                  clk,
	input  logic                  rst,
	input  rv_isa_pkg::reg_addr_t rs1_addr,
	input  rv_isa_pkg::reg_addr_t rs2_addr,
	input  rv_isa_pkg::reg_addr_t wr_rd,
	input  logic                  wr_en,
	input  rv_core_pkg::word_t    wr_value,
	output rv_core_pkg::word_t    rs1_value,
	output rv_core_pkg::word_t    rs2_value
);

	rv_core_pkg::word_t regs [1:31]; // x0 has no storage

	function automatic rv_core_pkg::word_t read_port(input rv_isa_pkg::reg_addr_t addr);
		if (addr == 5'd0)
			return '0;
		else if (wr_en && (wr_rd == addr)) // Write-through
			return wr_value;
		else
			return regs[addr];
	endfunction

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (wr_en && (wr_rd != 5'd0)) begin
			regs[wr_rd] <= wr_value;
		end
	end

	always_comb begin
		rs1_value = read_port(rs1_addr);
		rs2_value = read_port(rs2_addr);
	end

endmodule

/* rtl/rv_core_pkg.sv */
package rv_core_pkg;

	typedef logic [31:0] word_t;

	// ========================================================================
	// ALU operation codes
	// ========================================================================
	typedef logic [3:0] alu_op_t;

	localparam alu_op_t ALU_ADD    = 4'h0;
	localparam alu_op_t ALU_SUB    = 4'h1;
	localparam alu_op_t ALU_AND    = 4'h2;
	localparam alu_op_t ALU_OR     = 4'h3;
	localparam alu_op_t ALU_XOR    = 4'h4;
	localparam alu_op_t ALU_PASS_A = 4'h5;
	localparam alu_op_t ALU_LTU    = 4'h7;
	localparam alu_op_t ALU_LT     = 4'h8;
	localparam alu_op_t ALU_SLL    = 4'h9;
	localparam alu_op_t ALU_SRL    = 4'hA;
	localparam alu_op_t ALU_SRA    = 4'hB;
	localparam alu_op_t ALU_PASS_B = 4'hC;

	// B operand select
	typedef logic [1:0] src_b_t;

	localparam src_b_t SRC_B_IMM  = 2'd0;
	localparam src_b_t SRC_B_RS2  = 2'd1;
	localparam src_b_t SRC_B_FOUR = 2'd2;

	typedef logic [2:0] branch_kind_t; // funct3 of the branch

	typedef enum logic [1:0] {
		SEQ_BOOT0,
		SEQ_BOOT1,
		SEQ_RUN
	} seq_state_e;

	localparam word_t INST_STEP = 32'd4;

endpackage

/* rtl/rv_core_top.sv */
`timescale 1ns/1ps

module rv_core_top #(
	parameter rv_core_pkg::word_t boot_addr = 32'h0000_0000
) (
	input  logic                  clk,
	input  logic                  rst,
	input  rv_isa_pkg::inst_t     inst,
	output rv_core_pkg::word_t    pc,
	output rv_core_pkg::word_t    wb_value,
	output logic                  wb_en,
	output rv_isa_pkg::reg_addr_t wb_rd
);

	rv_core_pkg::word_t        dec_pc, imm, rs1_value, rs2_value, jump_target;
	rv_core_pkg::word_t        ex_pc, ex_imm, ex_rs1, ex_rs2;
	rv_isa_pkg::reg_addr_t     rs1_addr, rs2_addr, rd_addr;
	rv_core_pkg::alu_op_t      alu_op, ex_op;
	rv_core_pkg::src_b_t       src_b, ex_src_b;
	rv_core_pkg::branch_kind_t branch_kind;
	logic                      src_a_pc, wr_en, is_branch, is_jump, jump_from_pc;
	logic                      ex_src_a_pc, boot_hold, boot_hold_q, redirect_req;
	logic                      redirect, flush;

	program_counter #(.boot_addr(boot_addr)) i_pc (
		.clk(clk), .rst(rst), .boot_hold(boot_hold_q), .redirect(redirect),
		.jump_target(jump_target), .pc(pc)
	);

	inst_decoder i_dec (
		.clk(clk), .rst(rst), .flush(flush), .inst(inst), .pc(pc),
		.dec_pc(dec_pc), .imm(imm), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
		.rd_addr(rd_addr), .alu_op(alu_op), .src_a_pc(src_a_pc), .src_b(src_b),
		.wr_en(wr_en), .is_branch(is_branch), .is_jump(is_jump),
		.jump_from_pc(jump_from_pc), .branch_kind(branch_kind)
	);

	pipeline_sequencer i_seq (
		.clk(clk), .rst(rst), .is_branch(is_branch), .is_jump(is_jump),
		.branch_kind(branch_kind), .rs1_value(rs1_value), .rs2_value(rs2_value),
		.boot_hold(boot_hold), .redirect_req(redirect_req)
	);

	reg_file i_rf (
		.clk(clk), .rst(rst), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
		.wr_rd(wb_rd), .wr_en(wb_en), .wr_value(wb_value),
		.rs1_value(rs1_value), .rs2_value(rs2_value)
	);

	id_ex_stage i_idex (
		.clk(clk), .rst(rst), .dec_pc(dec_pc), .imm(imm), .rd_addr(rd_addr),
		.alu_op(alu_op), .src_a_pc(src_a_pc), .src_b(src_b), .wr_en(wr_en),
		.jump_from_pc(jump_from_pc), .rs1_value(rs1_value), .rs2_value(rs2_value),
		.redirect_req(redirect_req), .boot_hold(boot_hold),
		.ex_pc(ex_pc), .ex_imm(ex_imm), .ex_rs1(ex_rs1), .ex_rs2(ex_rs2),
		.ex_op(ex_op), .ex_src_a_pc(ex_src_a_pc), .ex_src_b(ex_src_b),
		.ex_wr_en(wb_en), .ex_rd(wb_rd), .redirect(redirect), .flush(flush),
		.boot_hold_q(boot_hold_q), .jump_target(jump_target)
	);

	alu i_alu (
		.ex_op(ex_op), .ex_pc(ex_pc), .ex_rs1(ex_rs1), .ex_rs2(ex_rs2),
		.ex_imm(ex_imm), .ex_src_a_pc(ex_src_a_pc), .ex_src_b(ex_src_b),
		.result(wb_value)
	);

endmodule

/* rtl/rv_isa_pkg.sv */
package rv_isa_pkg;

	typedef logic [31:0] inst_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [6:0]  opcode_t;
	typedef logic [2:0]  funct3_t;
	typedef logic [6:0]  funct7_t;

	// ========================================================================
	// Major opcodes
	// ========================================================================
	localparam opcode_t OPC_OP_IMM = 7'b0010011;
	localparam opcode_t OPC_OP     = 7'b0110011;
	localparam opcode_t OPC_BRANCH = 7'b1100011;
	localparam opcode_t OPC_JAL    = 7'b1101111;
	localparam opcode_t OPC_JALR   = 7'b1100111;
	localparam opcode_t OPC_LUI    = 7'b0110111;
	localparam opcode_t OPC_AUIPC  = 7'b0010111;

	// Branch conditions
	localparam funct3_t F3_BEQ  = 3'b000;
	localparam funct3_t F3_BNE  = 3'b001;
	localparam funct3_t F3_BLT  = 3'b100;
	localparam funct3_t F3_BGE  = 3'b101;
	localparam funct3_t F3_BLTU = 3'b110;
	localparam funct3_t F3_BGEU = 3'b111;

	// Integer ops, shared by OP and OP-IMM
	localparam funct3_t F3_ADD  = 3'b000;
	localparam funct3_t F3_SLL  = 3'b001;
	localparam funct3_t F3_SLT  = 3'b010;
	localparam funct3_t F3_SLTU = 3'b011;
	localparam funct3_t F3_XOR  = 3'b100;
	localparam funct3_t F3_SR   = 3'b101;
	localparam funct3_t F3_OR   = 3'b110;
	localparam funct3_t F3_AND  = 3'b111;

	localparam funct7_t F7_BASE = 7'b0000000;
	localparam funct7_t F7_ALT  = 7'b0100000; // SUB / SRA

	localparam inst_t NOP_INST = 32'h0000_0013; // addi x0,x0,0

endpackage

/* run_sim.sh */
#!/bin/sh
# Build and run the core testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim_run.log

verilator --binary --timing -f src.f --top-module tb_rv_core -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_rv_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Testbench passed" "$LOG"; then
	exit 0
fi
exit 1

/* sim/program_cases.txt */
# I <address> <instruction>          program word, both hex
# E <test name> <rd> <value>         expected write in order, rd decimal, value hex
I 00000100 00500093  addi x1,x0,5
I 00000104 FFD00113  addi x2,x0,-3
I 00000108 FFE12193  slti x3,x2,-2
I 0000010C FFF0B213  sltiu x4,x1,-1
I 00000110 0F00C293  xori x5,x1,0xf0
I 00000114 0A00E313  ori x6,x1,0xa0
I 00000118 FF017393  andi x7,x2,-16
I 0000011C 00409413  slli x8,x1,4
I 00000120 01C15493  srli x9,x2,28
I 00000124 40115513  srai x10,x2,1
I 00000128 00A085B3  add x11,x1,x10
I 0000012C 40258633  sub x12,x11,x2
I 00000130 001616B3  sll x13,x12,x1
I 00000134 00D12733  slt x14,x2,x13
I 00000138 00E137B3  sltu x15,x2,x14
I 0000013C 0057C833  xor x16,x15,x5
I 00000140 010158B3  srl x17,x2,x16
I 00000144 41115933  sra x18,x2,x17
I 00000148 006979B3  and x19,x18,x6
I 0000014C 0089EA33  or x20,x19,x8
I 00000150 01480663  beq x16,x20,+12 taken
I 00000154 FFF00B13  addi x22,x0,-1 shadow
I 00000158 FFF00B13  addi x22,x0,-1 shadow
I 0000015C 00E08463  beq x1,x14,+8 not taken
I 00000160 00100A93  addi x21,x0,1
I 00000164 00E09663  bne x1,x14,+12 taken
I 00000168 FFF00B13  addi x22,x0,-1 shadow
I 0000016C FFF00B13  addi x22,x0,-1 shadow
I 00000170 01481463  bne x16,x20,+8 not taken
I 00000174 00200A93  addi x21,x0,2
I 00000178 00114663  blt x2,x1,+12 taken
I 0000017C FFF00B13  addi x22,x0,-1 shadow
I 00000180 FFF00B13  addi x22,x0,-1 shadow
I 00000184 0020C463  blt x1,x2,+8 not taken
I 00000188 00300A93  addi x21,x0,3
I 0000018C 0020D663  bge x1,x2,+12 taken
I 00000190 FFF00B13  addi x22,x0,-1 shadow
I 00000194 FFF00B13  addi x22,x0,-1 shadow
I 00000198 00115463  bge x2,x1,+8 not taken
I 0000019C 00400A93  addi x21,x0,4
I 000001A0 0020E663  bltu x1,x2,+12 taken
I 000001A4 FFF00B13  addi x22,x0,-1 shadow
I 000001A8 FFF00B13  addi x22,x0,-1 shadow
I 000001AC 00116463  bltu x2,x1,+8 not taken
I 000001B0 00500A93  addi x21,x0,5
I 000001B4 00117663  bgeu x2,x1,+12 taken
I 000001B8 FFF00B13  addi x22,x0,-1 shadow
I 000001BC FFF00B13  addi x22,x0,-1 shadow
I 000001C0 0020F463  bgeu x1,x2,+8 not taken
I 000001C4 00600A93  addi x21,x0,6
I 000001C8 ABCDEC37  lui x24,0xabcde
I 000001CC 00001C97  auipc x25,0x1
I 000001D0 00C00D6F  jal x26,+12
I 000001D4 FFF00B13  addi x22,x0,-1 shadow
I 000001D8 FFF00B13  addi x22,x0,-1 shadow
I 000001DC 1F000D93  addi x27,x0,0x1f0
I 000001E0 001D8E67  jalr x28,1(x27)
I 000001E4 FFF00B13  addi x22,x0,-1 shadow
I 000001E8 FFF00B13  addi x22,x0,-1 shadow
I 000001F0 004E0E93  addi x29,x28,4
I 000001F4 0000006F  jal x0,0
E addi 1 00000005
E addi_neg 2 FFFFFFFD
E slti 3 00000001
E sltiu 4 00000001
E xori 5 000000F5
E ori 6 000000A5
E andi 7 FFFFFFF0
E slli 8 00000050
E srli 9 0000000F
E srai 10 FFFFFFFE
E add 11 00000003
E sub 12 00000006
E sll 13 000000C0
E slt 14 00000001
E sltu 15 00000000
E xor 16 000000F5
E srl 17 000007FF
E sra 18 FFFFFFFF
E and 19 000000A5
E or 20 000000F5
E beq 21 00000001
E bne 21 00000002
E blt 21 00000003
E bge 21 00000004
E bltu 21 00000005
E bgeu 21 00000006
E lui 24 ABCDE000
E auipc 25 000011CC
E jal_link 26 000001D4
E jal_target 27 000001F0
E jalr_link 28 000001E4
E jalr_target 29 000001E8

/* sim/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;

	localparam rv_core_pkg::word_t BOOT_ADDR = 32'h0000_0100;
	localparam int WAIT_LIMIT   = 2000;
	localparam int DRAIN_CYCLES = 50;

	logic                  clk;
	logic                  rst;
	rv_isa_pkg::inst_t     inst;
	rv_core_pkg::word_t    pc;
	rv_core_pkg::word_t    wb_value;
	logic                  wb_en;
	rv_isa_pkg::reg_addr_t wb_rd;

	int seen_count;
	int check_errors;
	int tb_errors;
	int expected_count;

	rv_isa_pkg::inst_t imem [rv_core_pkg::word_t]; // Sparse, byte addressed

	rv_core_top #(.boot_addr(BOOT_ADDR)) i_dut (
		.clk(clk), .rst(rst), .inst(inst), .pc(pc),
		.wb_value(wb_value), .wb_en(wb_en), .wb_rd(wb_rd)
	);

	wb_checker #(.boot_addr(BOOT_ADDR)) i_checker (
		.clk(clk), .rst(rst), .pc(pc), .wb_en(wb_en), .wb_rd(wb_rd),
		.wb_value(wb_value), .seen_count(seen_count), .error_count(check_errors)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic rv_isa_pkg::inst_t fetch_word(input rv_core_pkg::word_t addr);
		if (imem.exists(addr))
			return imem[addr];
		else
			return rv_isa_pkg::NOP_INST; // Holes in the program
	endfunction

	// Instruction memory answers on the falling edge
	task automatic next_cycle();
		@(negedge clk);
		inst = fetch_word(pc);
	endtask

	// ========================================================================
	// Case file
	// ========================================================================
	task automatic load_cases();
		int                    fd;
		int                    fields;
		string                 line;
		string                 name;
		rv_core_pkg::word_t    addr;
		rv_core_pkg::word_t    value;
		rv_isa_pkg::inst_t     word;
		rv_isa_pkg::reg_addr_t rd;
		fd = $fopen("sim/program_cases.txt", "r");
		if (fd == 0) begin
			$display("Cannot open sim/program_cases.txt for reading");
			tb_errors++;
			return;
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() > 0 && line[0] == "I") begin
				fields = $sscanf(line, "I %h %h", addr, word);
				if (fields == 2)
					imem[addr] = word;
				else
					tb_errors++;
			end else if (line.len() > 0 && line[0] == "E") begin
				fields = $sscanf(line, "E %s %d %h", name, rd, value);
				if (fields == 3) begin
					i_checker.add_expected(name, rd, value);
					expected_count++;
				end else begin
					tb_errors++;
				end
			end
		end
		$fclose(fd);
		if (expected_count == 0) begin
			$display("The case file holds no expected writes");
			tb_errors++;
		end
	endtask

	task automatic wait_for_writes();
		int cycles;
		cycles = 0;
		while (seen_count < expected_count && cycles < WAIT_LIMIT) begin
			next_cycle();
			cycles++;
		end
		if (seen_count < expected_count) begin
			$display("Timed out after %0d cycles with %0d of %0d expected writes seen",
			         cycles, seen_count, expected_count);
			tb_errors++;
		end
	endtask

	initial begin
		rst            = 1'b1;
		inst           = rv_isa_pkg::NOP_INST;
		tb_errors      = 0;
		expected_count = 0;
		load_cases();
		repeat (8) next_cycle();
		rst = 1'b0;
		wait_for_writes();
		repeat (DRAIN_CYCLES) next_cycle(); // Let stray writes show up
		$display("Errors: %0d from checks, %0d from testbench, %0d of %0d writes seen",
		         check_errors, tb_errors, seen_count, expected_count);
		if (check_errors == 0 && tb_errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

/* sim/wb_checker.sv */
`timescale 1ns/1ps

module wb_checker #(
	parameter rv_core_pkg::word_t boot_addr = 32'h0000_0000
) (
	input  logic                  clk,
	input  logic                  rst,
	input  rv_core_pkg::word_t    pc,
	input  logic                  wb_en,
	input  rv_isa_pkg::reg_addr_t wb_rd,
	input  rv_core_pkg::word_t    wb_value,
	output int                    seen_count,
	output int                    error_count
);

	string                 exp_name  [$];
	rv_isa_pkg::reg_addr_t exp_rd    [$];
	rv_core_pkg::word_t    exp_value [$];

	int seen      = 0;
	int errors    = 0;
	int run_edges = 0; // Rising edges since reset release

	assign seen_count  = seen;
	assign error_count = errors;

	task automatic add_expected(input string name, input rv_isa_pkg::reg_addr_t rd,
	                            input rv_core_pkg::word_t value);
		exp_name.push_back(name);
		exp_rd.push_back(rd);
		exp_value.push_back(value);
	endtask

	task automatic compare_pc(input string name, input rv_core_pkg::word_t expected);
		if (pc !== expected) begin
			$display("CHECK FAILED %s: expected pc %08h, actual pc %08h", name, expected, pc);
			errors++;
		end
	endtask

	task automatic expect_write_idle(input string name);
		if (wb_en !== 1'b0) begin
			$display("CHECK FAILED %s: expected wb_en 0, actual wb_en %b", name, wb_en);
			errors++;
		end
	endtask

	task automatic compare_write();
		if (seen >= exp_rd.size()) begin
			$display("Write of %08h to x%0d arrived after the last expected write",
			         wb_value, wb_rd);
			errors++;
		end else begin
			if (wb_rd !== exp_rd[seen] || wb_value !== exp_value[seen]) begin
				$display("CHECK FAILED %s: expected x%0d = %08h, actual x%0d = %08h",
				         exp_name[seen], exp_rd[seen], exp_value[seen], wb_rd, wb_value);
				errors++;
			end
			seen++;
		end
	endtask

	// ========================================================================
	// Sampled before the DUT registers update
	// ========================================================================
	always @(posedge clk) begin
		if (rst) begin
			compare_pc("boot_pc_reset", boot_addr);
			expect_write_idle("boot_wb_reset");
		end else begin
			if (run_edges < 5)
				run_edges++;
			if (run_edges <= 3) // Two boot cycles, then first RUN cycle
				compare_pc("boot_pc_hold", boot_addr);
			else if (run_edges == 4)
				compare_pc("boot_pc_step", boot_addr + 32'd4);
			if (run_edges <= 2)
				expect_write_idle("boot_wb_hold"); // Boot states
			else if (wb_en && wb_rd != 5'd0)
				compare_write();
		end
	end

endmodule

/* src.f */
rtl/rv_isa_pkg.sv
rtl/rv_core_pkg.sv
rtl/program_counter.sv
rtl/pipeline_sequencer.sv
rtl/inst_decoder.sv
rtl/reg_file.sv
rtl/id_ex_stage.sv
rtl/alu.sv
rtl/rv_core_top.sv
sim/wb_checker.sv
sim/tb_rv_core.sv
